/* bench/core_assertions.sv */
// Concurrent checks on the radio core top: reset values, time counting, compat readback
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module core_assertions
   import core_pkg::*;
(
   input logic         dsp_clk,
   input logic         reset_i,
   input set_bus_t     set_i,
   input logic [3:0]   rb_addr_i,
   input logic [31:0]  rb_data_o,
   input clock_ctrl_t  clock_o,
   input serdes_ctrl_t serdes_o,
   input adc_ctrl_t    adc_o,
   input logic         phy_reset_n_o,
   input vita_time_t   vita_time_i
);

   vita_time_t time_q;
   logic       load_possible;

   // A load needs a low word write first, cleared once the jump is seen
   always_ff @(posedge dsp_clk) begin
      time_q <= vita_time_i;
      if (reset_i) begin
         load_possible <= 1'b0;
      end else if (set_i.stb && set_i.addr == 8'(`SR_TIME64 + 1)) begin
         load_possible <= 1'b1;
      end else if (vita_time_i != time_q + 64'd1) begin
         load_possible <= 1'b0;
      end
   end

   controls_at_reset: assert property (@(posedge dsp_clk) $past(reset_i) |->
      (clock_o == '0 && serdes_o == '0 && adc_o == '0 && phy_reset_n_o == 1'b1))
      else $error("Controls not at reset values after reset");

   time_counts: assert property (@(posedge dsp_clk) disable iff (reset_i)
      (!$past(reset_i) && !$past(load_possible)) |->
      (vita_time_i == $past(vita_time_i) + 64'd1))
      else $error("VITA time did not step by one without a load");

   compat_readback: assert property (@(posedge dsp_clk) disable iff (reset_i)
      (rb_addr_i == `RB_COMPAT) |=> (rb_data_o == `COMPAT_NUM))
      else $error("Compat word wrong one cycle after its address");

endmodule

bind core_top core_assertions u_assertions (
   .dsp_clk       (dsp_clk),
   .reset_i       (reset_i),
   .set_i         (set_i),
   .rb_addr_i     (rb_addr_i),
   .rb_data_o     (rb_data_o),
   .clock_o       (clock_o),
   .serdes_o      (serdes_o),
   .adc_o         (adc_o),
   .phy_reset_n_o (phy_reset_n_o),
   .vita_time_i   (vita_time)
);

`default_nettype wire

/* bench/core_tb.sv */
// Testbench for the radio core top, replaying a command file and checking the outputs
`timescale 1ns/1ps
`default_nettype none

module core_tb
   import core_pkg::*;
();

   localparam int CLK_PERIOD     = 100;
   localparam int RESET_CYCLES   = 8;
   // Upper bound on cycles for any one command, idle gap included
   localparam int CYCLES_PER_CMD = 64;

   logic          dsp_clk;
   logic          reset_i;
   set_bus_t      set_i;
   logic          pps_i;
   board_status_t status_i;
   logic [3:0]    rb_addr_i;
   logic [31:0]   rb_data_o;
   clock_ctrl_t   clock_o;
   serdes_ctrl_t  serdes_o;
   adc_ctrl_t     adc_o;
   logic          phy_reset_n_o;
   logic [7:0]    leds_o;

   string         cmd_op[$];
   logic [7:0]    cmd_addr[$];
   logic [31:0]   cmd_data[$];
   string         cmd_name[$];
   int            cmd_count = 0;

   core_top DUT (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .set_i         (set_i),
      .pps_i         (pps_i),
      .status_i      (status_i),
      .rb_addr_i     (rb_addr_i),
      .rb_data_o     (rb_data_o),
      .clock_o       (clock_o),
      .serdes_o      (serdes_o),
      .adc_o         (adc_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   task automatic load_commands();
      int          fd;
      int          n;
      string       line;
      string       op;
      string       name;
      logic [7:0]  addr;
      logic [31:0] data;
      fd = $fopen("bench/core_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the command file bench/core_testdata.txt");
         $display("Simulation failed");
         $fatal(1, "No command file");
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // Lines starting with # are column notes
         if (n > 0 && line.getc(0) != "#") begin
            if ($sscanf(line, "%s %h %h %s", op, addr, data, name) == 4) begin
               cmd_op.push_back(op);
               cmd_addr.push_back(addr);
               cmd_data.push_back(data);
               cmd_name.push_back(name);
            end
         end
      end
      $fclose(fd);
      cmd_count = cmd_op.size();
   endtask

   task automatic settings_write(input logic [7:0] waddr, input logic [31:0] wdata);
      @(posedge dsp_clk);
      set_i <= '{stb: 1'b1, addr: waddr, data: wdata};
      @(posedge dsp_clk);
      set_i <= '0;
   endtask

   // Word shows on rb_data_o one edge after the address
   task automatic read_word(input logic [3:0] raddr, output logic [31:0] value);
      @(posedge dsp_clk);
      rb_addr_i <= raddr;
      @(posedge dsp_clk);
      @(negedge dsp_clk);
      value = rb_data_o;
   endtask

   task automatic run_command(input string op, input logic [7:0] addr,
                              input logic [31:0] data, input string name);
      logic [31:0] value;
      logic [31:0] first;
      case (op)
         "WR": settings_write(addr, data);
         "ST": begin
            @(posedge dsp_clk);
            status_i <= board_status_t'(data[1:0]);
         end
         "PPS": begin
            @(posedge dsp_clk);
            pps_i <= 1'b1;
            repeat (data) @(posedge dsp_clk);
            pps_i <= 1'b0;
         end
         "IDLE": repeat (data) @(posedge dsp_clk);
         "RB": begin
            read_word(addr[3:0], value);
            check_value(name, data, value);
         end
         "RBLT": begin
            read_word(addr[3:0], value);
            check_value(name, 32'd1, {31'd0, value < data});
         end
         "RBD": begin
            // Two reads data cycles apart, the counter moved by exactly data
            read_word(addr[3:0], first);
            repeat (data) @(posedge dsp_clk);
            @(negedge dsp_clk);
            check_value(name, data, rb_data_o - first);
         end
         "LED": begin
            @(negedge dsp_clk);
            check_value(name, data, {24'd0, leds_o});
         end
         "CTL": begin
            // Layout {phy_n, adc, serdes, 3'b0, clock}
            @(negedge dsp_clk);
            check_value(name, data, {15'd0, phy_reset_n_o, adc_o, serdes_o, 3'd0, clock_o});
         end
         default: begin
            $display("Unknown command %s in the command file", op);
            $display("Simulation failed");
            $fatal(1, "Bad command");
         end
      endcase
   endtask

   //////////////////////////////////////////////////////////////////////
   // Stimulus and watchdog

   initial begin
      int gap;
      void'($urandom(32'hfe991410));
      reset_i   = 1'b1;
      set_i     = '0;
      pps_i     = 1'b0;
      status_i  = '0;
      rb_addr_i = '0;
      load_commands();
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      reset_i <= 1'b0;
      for (int i = 0; i < cmd_count; i++) begin
         gap = $urandom % 4;
         repeat (gap) @(posedge dsp_clk);
         run_command(cmd_op[i], cmd_addr[i], cmd_data[i], cmd_name[i]);
      end
      repeat (2) @(posedge dsp_clk);
      if (cmd_count == 0) begin
         $display("The command file held no commands");
         $display("Simulation failed");
         $fatal(1, "Empty command file");
      end else begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

   initial begin
      wait (cmd_count > 0);
      #((RESET_CYCLES + cmd_count * CYCLES_PER_CMD) * CLK_PERIOD);
      $display("Timeout, the command list did not finish in time");
      $display("Simulation failed");
      $fatal(1, "Watchdog");
   end

endmodule

`default_nettype wire

/* bench/core_testdata.txt */
# op addr data name : WR settings write, ST status, PPS and IDLE take cycles in data
# RB/RBLT/RBD readback word addr, LED/CTL expected outputs (CTL = {phy_n,adc,serdes,0,clock})
ST   00 00000002 status_clk_only
CTL  00 00010000 reset_controls
LED  00 00000004 reset_leds
RB   0c 00090000 compat_number
RB   0d 00000800 status_word
WR   00 fffffff5 wr_clock
WR   01 0000000a wr_serdes
WR   02 00000006 wr_adc
WR   04 00000001 wr_phy_reset
CTL  00 00006a15 control_writes
WR   05 ffffffff wr_unused
CTL  00 00006a15 unused_offset_controls
LED  00 00000004 unused_offset_leds
WR   03 000000a5 wr_led_sw
WR   06 0000000f wr_led_src
ST   00 00000003 status_both
LED  00 000000a4 led_mix
WR   0c 00000001 wr_ctrl_immediate
WR   0a 12345678 wr_time_hi
WR   0b 00001000 wr_time_lo
RB   0a 12345678 immediate_time_hi
RBD  0b 00000007 immediate_time_step
WR   0c 00000000 wr_ctrl_pps
WR   0a abcd0000 wr_pps_time_hi
WR   0b 00000100 wr_pps_time_lo
IDLE 00 00000010 wait_armed
RB   0a 12345678 pps_not_yet_loaded
LED  00 000000a4 leds_before_pps
PPS  00 00000006 pps_pulse
RB   0a abcd0000 pps_time_hi
RBLT 0e abcd0000 pps_latch_below_load
LED  00 000000a6 leds_good_sync

/* filelist.f */
+incdir+include
rtl/core_pkg.sv
rtl/misc_ctrl.sv
rtl/vita_time_64.sv
rtl/readback_mux.sv
rtl/core_top.sv
bench/core_assertions.sv
bench/core_tb.sv

/* include/core_cfg.svh */
// Settings bus map, readback word indices and fixed constants of the radio core
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Settings bus base addresses

// Misc control registers, seven slots (offset 5 unused)
`define SR_MISC 0

// VITA time registers: hi, lo, control
`define SR_TIME64 10

//////////////////////////////////////////////////////////////////////
// LED source at reset

// A 1 bit hands that LED to the hardware pattern
`define LED_SRC_AT_RESET 8'h1E

//////////////////////////////////////////////////////////////////////
// Readback

// Major 9, minor 0
`define COMPAT_NUM {16'd9, 16'd0}

// Word indices of the status readback
`define RB_TIME_HI 4'd10
`define RB_TIME_LO 4'd11
`define RB_COMPAT  4'd12
`define RB_STATUS  4'd13
`define RB_PPS_HI  4'd14
`define RB_PPS_LO  4'd15

`endif

/* rtl/core_pkg.sv */
// Shared types of the radio core: settings bus, control groups and board status
`default_nettype none

package core_pkg;

   // One settings write, valid while stb is high
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Clock generator controls, in settings word bit order [4:0]
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   // SERDES controls, bits [3:0]
   typedef struct packed {
      logic ser_enable;
      logic ser_prbsen;
      logic ser_loopen;
      logic ser_rx_en;
   } serdes_ctrl_t;

   // ADC output and power enables, bits [3:0]
   typedef struct packed {
      logic adc_oe_a;
      logic adc_on_a;
      logic adc_oe_b;
      logic adc_on_b;
   } adc_ctrl_t;

   // Board status inputs
   typedef struct packed {
      logic clk_status;
      logic serdes_link_up;
   } board_status_t;

   // VITA time in ticks
   typedef logic [63:0] vita_time_t;

endpackage

`default_nettype wire

/* rtl/core_top.sv */
// Radio core top on dsp_clk: misc controls, VITA time and status readback
`timescale 1ns/1ps
`default_nettype none

module core_top
   import core_pkg::*;
(
   input  logic          dsp_clk,
   input  logic          reset_i,
   input  set_bus_t      set_i,
   input  logic          pps_i,
   input  board_status_t status_i,
   input  logic [3:0]    rb_addr_i,
   output logic [31:0]   rb_data_o,
   output clock_ctrl_t   clock_o,
   output serdes_ctrl_t  serdes_o,
   output adc_ctrl_t     adc_o,
   output logic          phy_reset_n_o,
   output logic [7:0]    leds_o
);

   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   logic       good_sync;

   //////////////////////////////////////////////////////////////////////
   // Misc controls and LEDs

   misc_ctrl u_misc (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .set_i         (set_i),
      .status_i      (status_i),
      .good_sync_i   (good_sync),
      .clock_o       (clock_o),
      .serdes_o      (serdes_o),
      .adc_o         (adc_o),
      .phy_reset_n_o (phy_reset_n_o),
      .leds_o        (leds_o)
   );

   //////////////////////////////////////////////////////////////////////
   // VITA time

   vita_time_64 u_time (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .set_i           (set_i),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync)
   );

   //////////////////////////////////////////////////////////////////////
   // Status readback

   readback_mux u_rb (
      .dsp_clk         (dsp_clk),
      .reset_i         (reset_i),
      .rb_addr_i       (rb_addr_i),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps),
      .status_i        (status_i),
      .rb_data_o       (rb_data_o)
   );

endmodule

`default_nettype wire

/* rtl/misc_ctrl.sv */
// Misc control registers driving clock gen, SERDES, ADC, PHY reset and the LED mix
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module misc_ctrl
   import core_pkg::*;
(
   input  logic          dsp_clk,
   input  logic          reset_i,
   input  set_bus_t      set_i,
   input  board_status_t status_i,
   input  logic          good_sync_i,
   output clock_ctrl_t   clock_o,
   output serdes_ctrl_t  serdes_o,
   output adc_ctrl_t     adc_o,
   output logic          phy_reset_n_o,
   output logic [7:0]    leds_o
);

   localparam logic [7:0] ADDR_CLOCK   = 8'(`SR_MISC + 0);
   localparam logic [7:0] ADDR_SERDES  = 8'(`SR_MISC + 1);
   localparam logic [7:0] ADDR_ADC     = 8'(`SR_MISC + 2);
   localparam logic [7:0] ADDR_LED_SW  = 8'(`SR_MISC + 3);
   localparam logic [7:0] ADDR_PHY     = 8'(`SR_MISC + 4);
   localparam logic [7:0] ADDR_LED_SRC = 8'(`SR_MISC + 6);

   clock_ctrl_t  clock_r;
   serdes_ctrl_t serdes_r;
   adc_ctrl_t    adc_r;
   logic [7:0]   led_sw_r;
   logic [7:0]   led_src_r;
   logic         phy_reset_r;
   logic [7:0]   led_hw;

   //////////////////////////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         clock_r     <= '0;
         serdes_r    <= '0;
         adc_r       <= '0;
         led_sw_r    <= '0;
         led_src_r   <= `LED_SRC_AT_RESET;
         phy_reset_r <= 1'b0;
      end else if (set_i.stb) begin
         // Each register keeps only the low bits its struct needs
         case (set_i.addr)
            ADDR_CLOCK: begin
               clock_r <= clock_ctrl_t'(set_i.data[$bits(clock_ctrl_t)-1:0]);
            end
            ADDR_SERDES: begin
               serdes_r <= serdes_ctrl_t'(set_i.data[$bits(serdes_ctrl_t)-1:0]);
            end
            ADDR_ADC: begin
               adc_r <= adc_ctrl_t'(set_i.data[$bits(adc_ctrl_t)-1:0]);
            end
            ADDR_LED_SW: begin
               led_sw_r <= set_i.data[7:0];
            end
            ADDR_PHY: begin
               phy_reset_r <= set_i.data[0];
            end
            ADDR_LED_SRC: begin
               led_src_r <= set_i.data[7:0];
            end
            default: begin
               // Offset 5 and foreign addresses leave everything alone
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Outputs

   assign clock_o  = clock_r;
   assign serdes_o = serdes_r;
   assign adc_o    = adc_r;

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_reset_r;

   // Hardware pattern, only the status LEDs remain
   assign led_hw = {5'b0, status_i.clk_status, status_i.serdes_link_up & good_sync_i, 1'b0};

   // Per bit: 1 in led_src selects hardware, 0 selects software
   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

endmodule

`default_nettype wire

/* rtl/readback_mux.sv */
// Registered 16-word status readback: time, PPS time, compat number and board status
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module readback_mux
   import core_pkg::*;
(
   input  logic          dsp_clk,
   input  logic          reset_i,
   input  logic [3:0]    rb_addr_i,
   input  vita_time_t    vita_time_i,
   input  vita_time_t    vita_time_pps_i,
   input  board_status_t status_i,
   output logic [31:0]   rb_data_o
);

   logic [31:0] word_sel;
   logic [31:0] status_word;
   logic [31:0] rb_data_r;

   // Status bits sit at 11 and 10 as software expects
   assign status_word = {20'b0, status_i.clk_status, status_i.serdes_link_up, 10'b0};

   always_comb begin
      case (rb_addr_i)
         `RB_TIME_HI: word_sel = vita_time_i[63:32];
         `RB_TIME_LO: word_sel = vita_time_i[31:0];
         `RB_COMPAT:  word_sel = `COMPAT_NUM;
         `RB_STATUS:  word_sel = status_word;
         `RB_PPS_HI:  word_sel = vita_time_pps_i[63:32];
         `RB_PPS_LO:  word_sel = vita_time_pps_i[31:0];
         default:     word_sel = 32'd0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // One cycle of latency, time words sampled here

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         rb_data_r <= 32'd0;
      end else begin
         rb_data_r <= word_sel;
      end
   end

   assign rb_data_o = rb_data_r;

endmodule

`default_nettype wire

/* rtl/vita_time_64.sv */
// 64-bit VITA time counter with immediate or PPS-timed load, PPS latch and sync flag
`timescale 1ns/1ps
`default_nettype none

`include "core_cfg.svh"

module vita_time_64
   import core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       reset_i,
   input  set_bus_t   set_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o,
   output logic       good_sync_o
);

   localparam logic [7:0] ADDR_TIME_HI = 8'(`SR_TIME64 + 0);
   localparam logic [7:0] ADDR_TIME_LO = 8'(`SR_TIME64 + 1);
   localparam logic [7:0] ADDR_CTRL    = 8'(`SR_TIME64 + 2);

   logic        wr_hi;
   logic        wr_lo;
   logic        wr_ctrl;

   logic [31:0] pending_hi;
   logic [31:0] pending_lo;
   logic        armed;
   logic        imm_mode;

   logic        pps_meta;
   logic        pps_sync;
   logic        pps_del;
   logic        pps_edge;
   logic        load_now;

   vita_time_t  time_r;
   vita_time_t  time_pps_r;
   logic        good_sync_r;

   assign wr_hi   = set_i.stb && (set_i.addr == ADDR_TIME_HI);
   assign wr_lo   = set_i.stb && (set_i.addr == ADDR_TIME_LO);
   assign wr_ctrl = set_i.stb && (set_i.addr == ADDR_CTRL);

   //////////////////////////////////////////////////////////////////////
   // Pending time, loaded into the counter later

   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         pending_hi <= set_i.data;
      end
      if (wr_lo) begin
         pending_lo <= set_i.data;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge detect

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_del  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_del  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_del;

   // Armed load goes now in immediate mode, else waits for the PPS edge
   assign load_now = armed & (imm_mode | pps_edge);

   //////////////////////////////////////////////////////////////////////
   // Counter, PPS latch and sync tracking

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         time_r      <= '0;
         time_pps_r  <= '0;
         good_sync_r <= 1'b0;
         armed       <= 1'b0;
         imm_mode    <= 1'b0;
      end else begin
         if (wr_ctrl) begin
            imm_mode <= set_i.data[0];
         end

         if (load_now) begin
            time_r      <= {pending_hi, pending_lo};
            good_sync_r <= ~imm_mode;
            armed       <= 1'b0;
         end else begin
            time_r <= time_r + 64'd1;
         end

         // A fresh low word re-arms, even in the cycle of a load
         if (wr_lo) begin
            armed <= 1'b1;
         end

         // Time as it stood just before any load on this edge
         if (pps_edge) begin
            time_pps_r <= time_r;
         end
      end
   end

   assign vita_time_o     = time_r;
   assign vita_time_pps_o = time_pps_r;
   assign good_sync_o     = good_sync_r;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the radio core testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module core_tb -f filelist.f -o core_sim || exit 1
result=$(./obj_dir/core_sim)
echo "$result"
echo "$result" | grep -q "Simulation completed successfully" && echo "PASSED" || { echo "FAILED"; exit 1; }
